//--- rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // cache geometry
    localparam int way_cnt       = 2;
    localparam int way_bits      = 1;
    localparam int set_cnt       = 16;
    localparam int line_words    = 4;
    localparam int offset_bits   = 4;
    localparam int index_bits    = 4;
    localparam int tag_bits      = 24;
    localparam int word_sel_bits = 2;
    localparam int data_depth    = set_cnt * line_words;

    // victim lfsr start value, any nonzero pattern
    localparam logic [7:0] lfsr_seed = 8'hb5;

    typedef logic [31:0] word_t;
    typedef logic [way_cnt-1:0] way_sel_t;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [tag_bits-1:0] tag;
    } tag_entry_t;

    // wishbone classic request, same layout on both sides
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        word_t       dat;
        logic [3:0]  sel;
    } cpu_req_t;

    typedef cpu_req_t mem_req_t;

    function automatic logic [tag_bits-1:0] adr_tag(input logic [31:0] adr);
        return adr[offset_bits+index_bits +: tag_bits];
    endfunction

    function automatic logic [index_bits-1:0] adr_index(input logic [31:0] adr);
        return adr[offset_bits +: index_bits];
    endfunction

    function automatic logic [word_sel_bits-1:0] adr_word(input logic [31:0] adr);
        return adr[2 +: word_sel_bits];
    endfunction

    // byte address of one word inside a line
    function automatic logic [31:0] line_adr(
        input logic [tag_bits-1:0]      tag,
        input logic [index_bits-1:0]    index,
        input logic [word_sel_bits-1:0] word
    );
        return {tag, index, word, 2'b00};
    endfunction

endpackage

`default_nettype wire

//--- rtl/cache_ram.sv
`default_nettype none

module cache_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  depth   = 16
) (
    input  wire logic                     clk,
    input  wire logic [$clog2(depth)-1:0] addr_i,
    input  wire logic                     we_i,
    input  wire entry_t                   wdata_i,
    output entry_t                        rdata_o
);

    entry_t mem [depth];

    // write first into the array, the read port still returns the old entry
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // registered read, one cycle after the address
    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

//--- rtl/dcache_lookup.sv
`default_nettype none

module dcache_lookup (
    input  wire logic                                          clk,
    input  wire logic                                          rst_n,
    input  wire dcache_pkg::tag_entry_t [dcache_pkg::way_cnt-1:0] tags_i,
    input  wire dcache_pkg::word_t [dcache_pkg::way_cnt-1:0]      words_i,
    input  wire logic [31:0]                                   adr_i,
    input  wire dcache_pkg::word_t                             wdat_i,
    input  wire logic [3:0]                                    sel_i,
    input  wire logic                                          lfsr_step_i,
    output logic                                               hit_o,
    output dcache_pkg::way_sel_t                               hit_way_o,
    output dcache_pkg::way_sel_t                               victim_way_o,
    output logic                                               victim_dirty_o,
    output logic [dcache_pkg::tag_bits-1:0]                    victim_tag_o,
    output dcache_pkg::word_t                                  rd_word_o,
    output dcache_pkg::word_t                                  merged_word_o
);

    logic [7:0]           lfsr_q;
    dcache_pkg::way_sel_t invalid_ways;
    dcache_pkg::way_sel_t word_way;

    // tag compare per way
    always_comb begin
        for (int w = 0; w < dcache_pkg::way_cnt; w++) begin
            hit_way_o[w]    = tags_i[w].valid &&
                              (tags_i[w].tag == dcache_pkg::adr_tag(adr_i));
            invalid_ways[w] = !tags_i[w].valid;
        end
    end

    assign hit_o = |hit_way_o;

    // random pick, but the lowest invalid way wins
    always_comb begin
        victim_way_o = '0;
        victim_way_o[lfsr_q[dcache_pkg::way_bits-1:0]] = 1'b1;
        for (int w = dcache_pkg::way_cnt - 1; w >= 0; w--) begin
            if (invalid_ways[w]) begin
                victim_way_o    = '0;
                victim_way_o[w] = 1'b1;
            end
        end
    end

    // on a miss the word mux follows the victim, which feeds write-back
    assign word_way = hit_o ? hit_way_o : victim_way_o;

    always_comb begin
        victim_dirty_o = 1'b0;
        victim_tag_o   = '0;
        rd_word_o      = '0;
        for (int w = 0; w < dcache_pkg::way_cnt; w++) begin
            if (victim_way_o[w]) begin
                victim_dirty_o = tags_i[w].valid && tags_i[w].dirty;
                victim_tag_o   = tags_i[w].tag;
            end
            if (word_way[w]) begin
                rd_word_o = words_i[w];
            end
        end
    end

    // store data is already lane aligned, sel picks the bytes
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged_word_o[8*b +: 8] = sel_i[b] ? wdat_i[8*b +: 8] : rd_word_o[8*b +: 8];
        end
    end

    // x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr_q <= dcache_pkg::lfsr_seed;
        end else if (lfsr_step_i) begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

endmodule

`default_nettype wire

//--- rtl/dcache_ctrl.sv
`default_nettype none

module dcache_ctrl (
    input  wire logic                                  clk,
    input  wire logic                                  rst_n,
    input  wire dcache_pkg::cpu_req_t                  cpu_req_i,
    output logic                                       cpu_ack_o,
    output dcache_pkg::word_t                          cpu_dat_o,
    output dcache_pkg::mem_req_t                       mem_req_o,
    input  wire logic                                  mem_ack_i,
    input  wire dcache_pkg::word_t                     mem_dat_i,
    output logic [dcache_pkg::index_bits-1:0]          tag_addr_o,
    output logic [dcache_pkg::index_bits+1:0]          data_addr_o,
    output dcache_pkg::way_sel_t                       tag_we_o,
    output dcache_pkg::way_sel_t                       data_we_o,
    output dcache_pkg::tag_entry_t                     tag_wdata_o,
    output dcache_pkg::word_t                          data_wdata_o,
    input  wire logic                                  hit_i,
    input  wire dcache_pkg::way_sel_t                  hit_way_i,
    input  wire dcache_pkg::way_sel_t                  victim_way_i,
    input  wire logic                                  victim_dirty_i,
    input  wire logic [dcache_pkg::tag_bits-1:0]       victim_tag_i,
    input  wire dcache_pkg::word_t                     rd_word_i,
    input  wire dcache_pkg::word_t                     merged_word_i,
    output logic                                       lfsr_step_o
);

    typedef enum logic [2:0] {
        st_sweep,
        st_idle,
        st_read,
        st_compare,
        st_write_back,
        st_refill,
        st_ack
    } state_t;

    state_t                                 state_q;
    state_t                                 state_d;
    logic [dcache_pkg::index_bits-1:0]      sweep_q;
    logic [dcache_pkg::word_sel_bits-1:0]   cnt_q;
    logic                                   wb_rd_q;
    dcache_pkg::way_sel_t                   victim_way_q;
    logic [dcache_pkg::tag_bits-1:0]        victim_tag_q;
    logic [dcache_pkg::index_bits-1:0]      req_index;
    logic                                   mem_stb;
    logic                                   mem_done;
    logic                                   last_word;

    assign req_index = dcache_pkg::adr_index(cpu_req_i.adr);
    // write-back waits one cycle for each victim word to come out of the RAM
    assign mem_stb   = (state_q == st_write_back && wb_rd_q) || state_q == st_refill;
    assign mem_done  = mem_stb && mem_ack_i;
    assign last_word = &cnt_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_sweep: begin
                if (&sweep_q) begin
                    state_d = st_idle;
                end
            end
            st_idle: begin
                if (cpu_req_i.cyc && cpu_req_i.stb) begin
                    state_d = st_compare;
                end
            end
            st_read: begin
                state_d = st_compare;
            end
            st_compare: begin
                if (hit_i) begin
                    state_d = st_ack;
                end else if (victim_dirty_i) begin
                    state_d = st_write_back;
                end else begin
                    state_d = st_refill;
                end
            end
            st_write_back: begin
                if (mem_done && last_word) begin
                    state_d = st_refill;
                end
            end
            st_refill: begin
                // line is in place, look it up again
                if (mem_done && last_word) begin
                    state_d = st_read;
                end
            end
            st_ack: begin
                state_d = st_idle;
            end
            default: begin
                state_d = st_sweep;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= st_sweep;
            sweep_q <= '0;
            cnt_q   <= '0;
            wb_rd_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == st_sweep) begin
                sweep_q <= sweep_q + 1'b1;
            end
            // wraps to zero after write-back, ready for the refill
            if (state_q == st_compare) begin
                cnt_q <= '0;
            end else if (mem_done) begin
                cnt_q <= cnt_q + 1'b1;
            end
            wb_rd_q <= (state_q == st_write_back) && !mem_done;
        end
    end

    // victim captured at the miss
    always_ff @(posedge clk) begin
        if (state_q == st_compare) begin
            victim_way_q <= victim_way_i;
            victim_tag_q <= victim_tag_i;
        end
    end

    // step on every refill start
    assign lfsr_step_o = (state_q == st_compare && !hit_i && !victim_dirty_i) ||
                         (state_q == st_write_back && mem_done && last_word);

    assign tag_addr_o  = (state_q == st_sweep) ? sweep_q : req_index;
    assign data_addr_o = {req_index,
                          (state_q == st_write_back || state_q == st_refill) ?
                          cnt_q : dcache_pkg::adr_word(cpu_req_i.adr)};

    always_comb begin
        tag_we_o     = '0;
        data_we_o    = '0;
        tag_wdata_o  = '0;
        data_wdata_o = merged_word_i;
        case (state_q)
            st_sweep: begin
                tag_we_o = '1;
            end
            st_refill: begin
                data_wdata_o      = mem_dat_i;
                tag_wdata_o.valid = 1'b1;
                tag_wdata_o.tag   = dcache_pkg::adr_tag(cpu_req_i.adr);
                if (mem_done) begin
                    data_we_o = victim_way_q;
                end
                // clean tag goes in with the last word
                if (mem_done && last_word) begin
                    tag_we_o = victim_way_q;
                end
            end
            st_ack: begin
                tag_wdata_o.valid = 1'b1;
                tag_wdata_o.dirty = 1'b1;
                tag_wdata_o.tag   = dcache_pkg::adr_tag(cpu_req_i.adr);
                if (cpu_req_i.we) begin
                    data_we_o = hit_way_i;
                    tag_we_o  = hit_way_i;
                end
            end
            default: begin
            end
        endcase
    end

    // whole-word single transfers only
    always_comb begin
        mem_req_o     = '0;
        mem_req_o.cyc = mem_stb;
        mem_req_o.stb = mem_stb;
        mem_req_o.we  = state_q == st_write_back && wb_rd_q;
        mem_req_o.sel = 4'hf;
        mem_req_o.dat = rd_word_i;
        if (state_q == st_write_back) begin
            mem_req_o.adr = dcache_pkg::line_adr(victim_tag_q, req_index, cnt_q);
        end else begin
            mem_req_o.adr = dcache_pkg::line_adr(dcache_pkg::adr_tag(cpu_req_i.adr),
                                                 req_index, cnt_q);
        end
    end

    assign cpu_ack_o = state_q == st_ack;
    assign cpu_dat_o = rd_word_i;

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
`default_nettype none

module dcache_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire dcache_pkg::cpu_req_t cpu_req_i,
    output logic                      cpu_ack_o,
    output dcache_pkg::word_t         cpu_dat_o,
    output dcache_pkg::mem_req_t      mem_req_o,
    input  wire logic                 mem_ack_i,
    input  wire dcache_pkg::word_t    mem_dat_i
);

    wire dcache_pkg::tag_entry_t [dcache_pkg::way_cnt-1:0] tags;
    wire dcache_pkg::word_t [dcache_pkg::way_cnt-1:0]      words;

    wire logic [dcache_pkg::index_bits-1:0] tag_addr;
    wire logic [dcache_pkg::index_bits+1:0] data_addr;
    wire dcache_pkg::way_sel_t              tag_we;
    wire dcache_pkg::way_sel_t              data_we;
    wire dcache_pkg::tag_entry_t            tag_wdata;
    wire dcache_pkg::word_t                 data_wdata;

    // lookup results
    wire logic                            hit;
    wire dcache_pkg::way_sel_t            hit_way;
    wire dcache_pkg::way_sel_t            victim_way;
    wire logic                            victim_dirty;
    wire logic [dcache_pkg::tag_bits-1:0] victim_tag;
    wire dcache_pkg::word_t               rd_word;
    wire dcache_pkg::word_t               merged_word;
    wire logic                            lfsr_step;

    // one tag RAM and one data RAM per way, shared address
    for (genvar w = 0; w < dcache_pkg::way_cnt; w++) begin : g_way
        cache_ram #(
            .entry_t(dcache_pkg::tag_entry_t),
            .depth  (dcache_pkg::set_cnt)
        ) i_tag_ram (
            .clk    (clk),
            .addr_i (tag_addr),
            .we_i   (tag_we[w]),
            .wdata_i(tag_wdata),
            .rdata_o(tags[w])
        );

        cache_ram #(
            .entry_t(dcache_pkg::word_t),
            .depth  (dcache_pkg::data_depth)
        ) i_data_ram (
            .clk    (clk),
            .addr_i (data_addr),
            .we_i   (data_we[w]),
            .wdata_i(data_wdata),
            .rdata_o(words[w])
        );
    end

    dcache_lookup i_lookup (
        .clk           (clk),
        .rst_n         (rst_n),
        .tags_i        (tags),
        .words_i       (words),
        .adr_i         (cpu_req_i.adr),
        .wdat_i        (cpu_req_i.dat),
        .sel_i         (cpu_req_i.sel),
        .lfsr_step_i   (lfsr_step),
        .hit_o         (hit),
        .hit_way_o     (hit_way),
        .victim_way_o  (victim_way),
        .victim_dirty_o(victim_dirty),
        .victim_tag_o  (victim_tag),
        .rd_word_o     (rd_word),
        .merged_word_o (merged_word)
    );

    dcache_ctrl i_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cpu_req_i     (cpu_req_i),
        .cpu_ack_o     (cpu_ack_o),
        .cpu_dat_o     (cpu_dat_o),
        .mem_req_o     (mem_req_o),
        .mem_ack_i     (mem_ack_i),
        .mem_dat_i     (mem_dat_i),
        .tag_addr_o    (tag_addr),
        .data_addr_o   (data_addr),
        .tag_we_o      (tag_we),
        .data_we_o     (data_we),
        .tag_wdata_o   (tag_wdata),
        .data_wdata_o  (data_wdata),
        .hit_i         (hit),
        .hit_way_i     (hit_way),
        .victim_way_i  (victim_way),
        .victim_dirty_i(victim_dirty),
        .victim_tag_i  (victim_tag),
        .rd_word_i     (rd_word),
        .merged_word_i (merged_word),
        .lfsr_step_o   (lfsr_step)
    );

endmodule

`default_nettype wire

//--- testbench/tb_dcache.sv
`default_nettype none

module tb_dcache;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          region_words = 256;
    localparam logic [31:0] seed         = 32'd63;
    localparam int          n_random     = 400;
    localparam int          n_repeat     = 64;
    localparam int          total_ops    = 1 + n_random + 2 * n_repeat + region_words;
    localparam int          ack_limit    = 200;

    logic                 clk;
    logic                 rst_n;
    dcache_pkg::cpu_req_t cpu_req;
    logic                 cpu_ack;
    dcache_pkg::word_t    cpu_dat;
    dcache_pkg::mem_req_t mem_req;
    logic                 mem_ack = 1'b0;
    dcache_pkg::word_t    mem_dat = '0;

    // bytes as the processor expects them
    logic [7:0]        model [4*region_words];
    dcache_pkg::word_t backing [region_words];
    // stores per line, and the store count at the last write-back of that line
    int                stored_cnt [64];
    int                wb_seen [64];
    logic [31:0]       stim_rng = seed;
    logic [31:0]       wait_rng = {seed[15:0], seed[31:16]};

    // memory slave state
    logic        busy = 1'b0;
    logic [1:0]  wait_left = 2'd0;
    logic [1:0]  grp_pos = 2'd0;
    logic [31:0] grp_base = '0;
    logic        grp_we = 1'b0;

    int mem_txns   = 0;
    int mem_errors = 0;
    int cpu_errors = 0;
    int checks     = 0;

    dcache_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_req_i(cpu_req),
        .cpu_ack_o(cpu_ack),
        .cpu_dat_o(cpu_dat),
        .mem_req_o(mem_req),
        .mem_ack_i(mem_ack),
        .mem_dat_i(mem_dat)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // initial memory contents, a function of the whole address
    function automatic dcache_pkg::word_t fill_word(input logic [31:0] adr);
        return (adr * 32'h0001_0003) ^ 32'h5ac3_9e17;
    endfunction

    function automatic dcache_pkg::word_t model_word(input logic [31:0] adr);
        dcache_pkg::word_t w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = model[{adr[9:2], b[1:0]}];
        end
        return w;
    endfunction

    task automatic draw(output logic [31:0] value);
        stim_rng = xorshift(stim_rng);
        value    = stim_rng;
    endtask

    // one wishbone classic cycle on the processor side
    task automatic cpu_access(
        input  logic              we,
        input  logic [31:0]       adr,
        input  dcache_pkg::word_t dat,
        input  logic [3:0]        sel,
        output dcache_pkg::word_t rdata,
        output int                latency
    );
        dcache_pkg::cpu_req_t req;
        logic                 acked;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = dat;
        req.sel = sel;
        acked   = 1'b0;
        latency = 0;
        rdata   = '0;
        @(posedge clk);
        cpu_req <= req;
        while (!acked && latency < ack_limit) begin
            @(posedge clk);
            latency++;
            acked = cpu_ack;
            rdata = cpu_dat;
        end
        cpu_req <= '0;
        if (!acked) begin
            cpu_errors++;
            $display("no acknowledge for the access to %h within %0d cycles", adr, ack_limit);
        end
    endtask

    task automatic read_check(input logic [31:0] adr, output int latency);
        dcache_pkg::word_t rdata;
        dcache_pkg::word_t expected;
        cpu_access(1'b0, adr, '0, 4'hf, rdata, latency);
        expected = model_word(adr);
        checks++;
        if (rdata !== expected) begin
            cpu_errors++;
            $display("MISMATCH cpu_dat_o at %h: expected %h, actual %h", adr, expected, rdata);
        end
    endtask

    task automatic store(input logic [31:0] adr, input dcache_pkg::word_t dat,
                         input logic [3:0] sel);
        dcache_pkg::word_t rdata;
        int                latency;
        cpu_access(1'b1, adr, dat, sel, rdata, latency);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                model[{adr[9:2], b[1:0]}] = dat[8*b +: 8];
            end
        end
        stored_cnt[adr[9:4]]++;
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        $display("test %0d %s done, %0d errors", num, name, cpu_errors + mem_errors - err_before);
    endtask

    // checks line grouping and write-back data, then answers
    task automatic serve_transaction;
        logic [31:0]       adr;
        dcache_pkg::word_t expected;
        adr = mem_req.adr;
        if (adr[31:10] != 22'd0 || mem_req.sel != 4'hf) begin
            mem_errors++;
            $display("memory access outside the region or with partial byte lanes at %h", adr);
        end
        if (grp_pos == 2'd0) begin
            grp_base = {adr[31:4], 4'h0};
            grp_we   = mem_req.we;
            if (adr[3:0] != 4'h0) begin
                mem_errors++;
                $display("memory group does not start at a line boundary: %h", adr);
            end
            if (grp_we && stored_cnt[adr[9:4]] == wb_seen[adr[9:4]]) begin
                mem_errors++;
                $display("write-back of line %h that holds no stored data", adr);
            end
        end else if (adr != grp_base + {28'd0, grp_pos, 2'b00} || mem_req.we != grp_we) begin
            mem_errors++;
            $display("memory transaction %h out of sequence in the group at %h", adr, grp_base);
        end
        if (mem_req.we) begin
            expected = model_word(adr);
            if (mem_req.dat !== expected) begin
                mem_errors++;
                $display("MISMATCH mem_req_o.dat at %h: expected %h, actual %h",
                         adr, expected, mem_req.dat);
            end
            backing[adr[9:2]] = mem_req.dat;
            if (grp_pos == 2'd3) begin
                wb_seen[adr[9:4]] = stored_cnt[adr[9:4]];
            end
        end else begin
            mem_dat <= backing[adr[9:2]];
        end
        grp_pos  = grp_pos + 2'd1;
        mem_ack  <= 1'b1;
        mem_txns <= mem_txns + 1;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // memory slave with 0 to 3 random wait cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_ack <= 1'b0;
            busy     = 1'b0;
            grp_pos  = 2'd0;
            for (int i = 0; i < region_words; i++) begin
                backing[i[7:0]] = fill_word({22'd0, i[7:0], 2'b00});
                if (i < 64) begin
                    wb_seen[i[5:0]] = 0;
                end
            end
        end else if (mem_ack) begin
            mem_ack <= 1'b0;
        end else if (mem_req.cyc && mem_req.stb) begin
            if (!busy) begin
                wait_rng  = xorshift(wait_rng);
                wait_left = wait_rng[1:0];
                busy      = 1'b1;
            end
            if (wait_left == 2'd0) begin
                busy = 1'b0;
                serve_transaction;
            end else begin
                wait_left = wait_left - 2'd1;
            end
        end
    end

    initial begin
        repeat (total_ops * 200) @(posedge clk);
        $display("watchdog: run not finished after %0d cycles", total_ops * 200);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0]       r;
        logic [31:0]       adr;
        dcache_pkg::word_t dat;
        logic [3:0]        sel;
        int                err_before;
        int                latency;
        int                txns_before;

        cpu_req <= '0;
        rst_n   <= 1'b0;
        for (int i = 0; i < 4 * region_words; i++) begin
            dat           = fill_word({22'd0, i[9:2], 2'b00});
            model[i[9:0]] = dat[8*i[1:0] +: 8];
        end
        for (int i = 0; i < 64; i++) begin
            stored_cnt[i[5:0]] = 0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // sweep runs here, nothing may move on either bus
        err_before = cpu_errors + mem_errors;
        repeat (24) begin
            @(posedge clk);
            checks++;
            if (mem_req.cyc || mem_req.stb || mem_req.we || cpu_ack) begin
                cpu_errors++;
                $display("memory bus or processor acknowledge active before the first request");
            end
        end
        report_test(1, "reset idle", err_before);

        err_before = cpu_errors + mem_errors;
        for (int n = 0; n < n_random; n++) begin
            draw(r);
            adr = {22'd0, r[9:2], 2'b00};
            draw(dat);
            draw(r);
            if (r[1:0] == 2'd0) begin
                sel = 4'hf;
            end else if (r[1:0] == 2'd1) begin
                sel = r[2] ? 4'hc : 4'h3;
            end else begin
                sel = 4'b0001 << r[4:3];
            end
            if (r[5]) begin
                store(adr, dat, sel);
            end else begin
                read_check(adr, latency);
            end
        end
        report_test(2, "random access", err_before);

        // second read must hit without touching memory
        err_before = cpu_errors + mem_errors;
        for (int n = 0; n < n_repeat; n++) begin
            draw(r);
            adr = {22'd0, r[9:2], 2'b00};
            read_check(adr, latency);
            txns_before = mem_txns;
            read_check(adr, latency);
            checks += 2;
            if (mem_txns != txns_before) begin
                cpu_errors++;
                $display("repeated read of %h caused %0d memory transactions",
                         adr, mem_txns - txns_before);
            end
            if (latency != 3) begin
                cpu_errors++;
                $display("hit on %h acknowledged after %0d cycles instead of 3", adr, latency);
            end
        end
        report_test(3, "repeated read", err_before);

        err_before = cpu_errors + mem_errors;
        for (int i = 0; i < region_words; i++) begin
            read_check({22'd0, i[7:0], 2'b00}, latency);
        end
        report_test(4, "region readback", err_before);

        $display("%0d checks, %0d memory transactions, %0d errors",
                 checks, mem_txns, cpu_errors + mem_errors);
        if (cpu_errors + mem_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/dcache_pkg.sv
rtl/cache_ram.sv
rtl/dcache_lookup.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
testbench/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps --top-module tb_dcache \
    -f verilog.f -o sim_dcache
out=$(./obj_dir/sim_dcache)
echo "$out"
if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
